// ==== source/pingpong_pkg.sv ====
package pingpong_pkg;

    // ====================
    // Widths
    // ====================
    localparam int unsigned SAMPLE_W   = 16;  // One data sample
    localparam int unsigned MAX_ADDR_W = 8;   // Caps DEPTH at 256

    typedef logic [SAMPLE_W-1:0]   sample_t;
    typedef logic [MAX_ADDR_W-1:0] addr_t;   // Position inside a bank
    typedef logic [MAX_ADDR_W:0]   count_t;  // Extra bit so DEPTH itself fits

    // ====================
    // Bundles
    // ====================
    // Write request towards the banks, 25 bits
    typedef struct packed {
        logic    en;    // Accepted write this cycle
        addr_t   addr;  // Slot in the write bank
        sample_t data;
    } wr_req_t;

    // Status towards the outside, 18 bits
    typedef struct packed {
        count_t write_count;  // Fill level of the write bank
        count_t read_count;   // Samples read from the read bank
    } buf_status_t;

    // Swap controller states
    typedef enum logic {
        FILLING,  // Write bank still taking samples
        SWAP      // One cycle, banks change roles
    } swap_state_t;

endpackage

// ==== source/swap_ctrl.sv ====
module swap_ctrl #(
    parameter int unsigned DEPTH = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  pingpong_pkg::count_t write_count_i,  // Fill level from write side
    output logic                 swap_o,         // High for the SWAP cycle
    output logic                 write_bank_o,   // 0 after reset
    output logic                 buffer_ready_o  // Full bank can be read
);
    import pingpong_pkg::*;

    localparam count_t DEPTH_C = count_t'(DEPTH);

    swap_state_t state_q, state_d;
    logic        bank_q;
    logic        ready_q;

    // ====================
    // Next state
    // ====================
    always_comb begin
        state_d = state_q;
        case (state_q)
            FILLING: if (write_count_i == DEPTH_C) state_d = SWAP;  // Bank full
            SWAP:    state_d = FILLING;                           // Always one cycle
            default: state_d = FILLING;
        endcase
    end

    assign swap_o = (state_q == SWAP);

    // ====================
    // Registers
    // ====================
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= FILLING;
            bank_q  <= 1'b0;  // Bank 0 fills first
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (swap_o) bank_q <= ~bank_q;  // Full bank turns into read bank
            ready_q <= swap_o;              // Pulse trails swap by one edge
        end
    end

    assign write_bank_o   = bank_q;
    assign buffer_ready_o = ready_q;

    // Swaps are at least two cycles apart, so the pulse stays single
    a_ready_single : assert property (
        @(posedge clk_i) disable iff (!rst_ni) buffer_ready_o |=> !buffer_ready_o
    );

endmodule

// ==== source/write_side.sv ====
module write_side #(
    parameter int unsigned DEPTH = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  pingpong_pkg::sample_t write_data_i,
    input  logic                  write_valid_i,
    output logic                  write_ready_o,
    input  logic                  swap_i,        // Restart in the fresh bank
    output pingpong_pkg::wr_req_t wr_req_o,      // To the banks
    output pingpong_pkg::count_t  write_count_o  // Fill level
);
    import pingpong_pkg::*;

    localparam count_t DEPTH_C = count_t'(DEPTH);

    addr_t  addr_q;   // Next slot to write
    count_t count_q;  // Samples held in the write bank
    logic   accept;

    assign write_ready_o = (count_q < DEPTH_C);  // Stalls once bank is full
    assign accept        = write_valid_i && write_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            addr_q  <= '0;
            count_q <= '0;
        end else if (swap_i) begin
            addr_q  <= '0;  // Fresh bank
            count_q <= '0;
        end else if (accept) begin
            addr_q  <= addr_q + addr_t'(1);
            count_q <= count_q + count_t'(1);
        end
    end

    // Memory takes the sample on the accepting edge
    assign wr_req_o.en   = accept;
    assign wr_req_o.addr = addr_q;
    assign wr_req_o.data = write_data_i;

    assign write_count_o = count_q;

    // Full bank holds off the memory until the swap
    a_count_max : assert property (@(posedge clk_i) disable iff (!rst_ni) count_q <= DEPTH_C);
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (count_q == DEPTH_C && write_valid_i) |-> !wr_req_o.en
    );

endmodule

// ==== source/read_side.sv ====
module read_side #(
    parameter int unsigned DEPTH = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 read_ready_i,
    output logic                 read_valid_o,
    input  logic                 swap_i,        // New full bank available
    output pingpong_pkg::addr_t  read_addr_o,   // Into the read bank
    output pingpong_pkg::count_t read_count_o   // Read position
);
    import pingpong_pkg::*;

    localparam count_t LAST_C  = count_t'(DEPTH - 1);

    logic   active_q;  // Bank has unread samples
    addr_t  addr_q;
    count_t count_q;
    logic   accept;
    logic   last;

    assign accept = active_q && read_ready_i;
    assign last   = (count_q == LAST_C);  // DEPTH-th read

    // ====================
    // Read position
    // ====================
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            active_q <= 1'b0;
            addr_q   <= '0;
            count_q  <= '0;
        end else if (swap_i) begin
            // Unread rest of the old bank is dropped here
            active_q <= 1'b1;
            addr_q   <= '0;
            count_q  <= '0;
        end else if (accept) begin
            count_q <= count_q + count_t'(1);
            if (last) begin
                active_q <= 1'b0;  // Drained bank stays idle until next swap
            end else begin
                addr_q <= addr_q + addr_t'(1);  // Address stays in range at end
            end
        end
    end

    assign read_valid_o = active_q;
    assign read_addr_o  = addr_q;
    assign read_count_o = count_q;

    // Valid only opens on a swap edge
    a_valid_on_swap : assert property (
        @(posedge clk_i) disable iff (!rst_ni) $rose(read_valid_o) |-> $past(swap_i)
    );

endmodule

// ==== source/pingpong_mem.sv ====
module pingpong_mem #(
    parameter int unsigned DEPTH = 16
) (
    input  logic                  clk_i,
    input  logic                  write_bank_i,  // Read bank is the other one
    input  pingpong_pkg::wr_req_t wr_req_i,
    input  pingpong_pkg::addr_t   read_addr_i,
    input  logic                  read_valid_i,
    output pingpong_pkg::sample_t read_data_o    // Zero while not valid
);
    import pingpong_pkg::*;

    // Index bits actually needed for DEPTH slots
    localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    sample_t          bank0 [DEPTH];
    sample_t          bank1 [DEPTH];
    logic    [AW-1:0] wr_idx;
    logic    [AW-1:0] rd_idx;
    sample_t          rd_sample;

    assign wr_idx = wr_req_i.addr[AW-1:0];
    assign rd_idx = read_addr_i[AW-1:0];

    // ====================
    // Write, synchronous
    // ====================
    always_ff @(posedge clk_i) begin
        if (wr_req_i.en) begin
            if (write_bank_i) begin
                bank1[wr_idx] <= wr_req_i.data;
            end else begin
                bank0[wr_idx] <= wr_req_i.data;
            end
        end
    end

    // ====================
    // Read, combinational
    // ====================
    always_comb begin
        if (write_bank_i) rd_sample = bank0[rd_idx];  // Writing 1, read 0
        else              rd_sample = bank1[rd_idx];
    end

    // Masked so stale bank contents never leak out
    assign read_data_o = read_valid_i ? rd_sample : '0;

endmodule

// ==== source/pingpong_top.sv ====
module pingpong_top #(
    parameter int unsigned DEPTH = 16  // Samples per bank
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // Write port
    input  pingpong_pkg::sample_t     write_data_i,
    input  logic                      write_valid_i,
    output logic                      write_ready_o,
    // Read port
    output pingpong_pkg::sample_t     read_data_o,
    output logic                      read_valid_o,
    input  logic                      read_ready_i,
    // Swap pulse and status
    output logic                      buffer_ready_o,
    output pingpong_pkg::buf_status_t status_o
);
    import pingpong_pkg::*;

    count_t  write_count;  // Fill level, watched by the controller
    count_t  read_count;
    logic    swap;         // One-cycle strobe to both sides
    logic    write_bank;   // Bank taking writes, other one is read
    wr_req_t wr_req;
    addr_t   read_addr;

    // ====================
    // Control
    // ====================
    swap_ctrl #(.DEPTH(DEPTH)) u_swap_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .write_count_i  (write_count),
        .swap_o         (swap),
        .write_bank_o   (write_bank),
        .buffer_ready_o (buffer_ready_o)
    );

    // ====================
    // Ports
    // ====================
    write_side #(.DEPTH(DEPTH)) u_write_side (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .write_data_i  (write_data_i),
        .write_valid_i (write_valid_i),
        .write_ready_o (write_ready_o),
        .swap_i        (swap),
        .wr_req_o      (wr_req),
        .write_count_o (write_count)
    );

    read_side #(.DEPTH(DEPTH)) u_read_side (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .read_ready_i (read_ready_i),
        .read_valid_o (read_valid_o),
        .swap_i       (swap),
        .read_addr_o  (read_addr),
        .read_count_o (read_count)
    );

    // Storage, read bank derived inside
    pingpong_mem #(.DEPTH(DEPTH)) u_mem (
        .clk_i        (clk_i),
        .write_bank_i (write_bank),
        .wr_req_i     (wr_req),
        .read_addr_i  (read_addr),
        .read_valid_i (read_valid_o),
        .read_data_o  (read_data_o)
    );

    assign status_o.write_count = write_count;
    assign status_o.read_count  = read_count;

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock #(
    parameter int unsigned PERIOD_NS    = 10,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset low for a fixed count, released just after an edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

// ==== tests/tb_pingpong.sv ====
module tb_pingpong;
    timeunit 1ns;
    timeprecision 100ps;

    import pingpong_pkg::*;

    localparam int DEPTH          = 16;
    localparam int CLK_NS         = 10;
    localparam int RESET_CYCLES   = 16;
    localparam int RAND_CYCLES    = 600;
    localparam int PLANNED_CYCLES = RESET_CYCLES + 6 * DEPTH + RAND_CYCLES + 40;
    localparam int WATCHDOG_NS    = 20 * PLANNED_CYCLES * CLK_NS;
    localparam logic [31:0] SEED  = 32'd14259;

    logic        clk_i;
    logic        rst_ni;
    sample_t     write_data;
    logic        write_valid;
    logic        write_ready;
    sample_t     read_data;
    logic        read_valid;
    logic        read_ready;
    logic        buffer_ready;
    buf_status_t status;

    // Reference state kept by the monitor
    sample_t wr_log[$];       // Every accepted write in order
    int      wr_fill     = 0;  // Expected fill of the write bank
    int      full_cycles = 0;  // Cycles seen with a full write bank
    int      pulse_cnt   = 0;
    int      cur_bank    = 0;  // Bank number behind the read port
    int      rd_pos      = 0;
    int      reads_done  = 0;
    logic    exp_valid   = 1'b0;
    logic [31:0] rng;

    tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    pingpong_top #(.DEPTH(DEPTH)) uut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .write_data_i   (write_data),
        .write_valid_i  (write_valid),
        .write_ready_o  (write_ready),
        .read_data_o    (read_data),
        .read_valid_o   (read_valid),
        .read_ready_i   (read_ready),
        .buffer_ready_o (buffer_ready),
        .status_o       (status)
    );

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // j-th read after the swap of bank k is write number k*DEPTH+j
    function automatic sample_t expected_read(input int bank, input int pos);
        return wr_log[bank * DEPTH + pos];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk_i);
        #1;  // Inputs change just after the edge
    endtask

    task automatic drive_cycle(input logic wv, input logic rr);
        rng         = xorshift32(rng);
        write_data  = rng[15:0];  // Fresh sample every cycle
        write_valid = wv;
        read_ready  = rr;
        wait_cycle();
    endtask

    // ====================
    // Monitor
    // ====================
    // Samples mid-cycle to see what the next edge will take
    initial begin : monitor
        logic exp_pulse;
        wait (rst_ni === 1'b1);
        forever begin
            @(negedge clk_i);
            exp_pulse = (full_cycles == 2);  // Swap lands two edges after the full edge
            check_value("buffer_ready_o", 32'(buffer_ready), 32'(exp_pulse));
            if (exp_pulse) begin
                cur_bank    = pulse_cnt;  // Unread rest of old bank dropped
                pulse_cnt   = pulse_cnt + 1;
                rd_pos      = 0;
                exp_valid   = 1'b1;
                wr_fill     = 0;
                full_cycles = 0;
            end
            if (wr_fill == DEPTH) full_cycles = full_cycles + 1;
            check_value("write_ready_o", 32'(write_ready), 32'(wr_fill < DEPTH));
            check_value("status_o.write_count", 32'(status.write_count), wr_fill);
            check_value("status_o.read_count", 32'(status.read_count), rd_pos);
            check_value("read_valid_o", 32'(read_valid), 32'(exp_valid));
            if (!read_valid) check_value("read_data_o", 32'(read_data), 0);  // Masked
            if (write_valid && write_ready) begin
                wr_log.push_back(write_data);
                wr_fill = wr_fill + 1;
            end
            if (read_valid && read_ready) begin
                check_value("read_data_o", 32'(read_data), 32'(expected_read(cur_bank, rd_pos)));
                rd_pos     = rd_pos + 1;
                reads_done = reads_done + 1;
                if (rd_pos == DEPTH) exp_valid = 1'b0;  // Drained
            end
        end
    end

    // ====================
    // Stimulus
    // ====================
    initial begin : stimulus
        int start;
        write_data  = '0;
        write_valid = 1'b0;
        read_ready  = 1'b0;
        rng         = SEED;
        wait (rst_ni === 1'b1);

        // Idle state right after reset
        check_value("write_ready_o", 32'(write_ready), 1);
        check_value("read_valid_o", 32'(read_valid), 0);
        check_value("buffer_ready_o", 32'(buffer_ready), 0);
        check_value("status_o", 32'(status), 0);

        // Back-to-back fill with valid held against the full bank
        start = pulse_cnt;
        while (pulse_cnt == start) drive_cycle(1'b1, 1'b0);

        // Drain one bank and idle with nothing to read
        while (read_valid) drive_cycle(1'b0, 1'b1);
        repeat (6) drive_cycle(1'b0, 1'b1);

        // Random stream with the reader mostly faster than the writer
        repeat (RAND_CYCLES) begin
            rng = xorshift32(rng);
            drive_cycle(rng[20], rng[31:30] != 2'b00);
        end

        // Stalled reader across two swaps
        start = pulse_cnt;
        while (pulse_cnt < start + 2) drive_cycle(1'b1, 1'b0);
        while (read_valid) drive_cycle(1'b0, 1'b1);
        repeat (8) drive_cycle(1'b0, 1'b0);

        check_value("reads_seen", 32'(reads_done > 4 * DEPTH), 1);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // ====================
    // Watchdog
    // ====================
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $fatal(1);
    end

endmodule

// ==== all.f ====
source/pingpong_pkg.sv
source/swap_ctrl.sv
source/write_side.sv
source/read_side.sv
source/pingpong_mem.sv
source/pingpong_top.sv
tests/tb_clock.sv
tests/tb_pingpong.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f all.f --top-module tb_pingpong -o sim_pingpong || exit 1
./obj_dir/sim_pingpong > sim.log 2>&1
cat sim.log
test -s sim.log || { echo "Simulation produced no log"; exit 1; }
grep -q "CHECKS FAILED" sim.log && echo "Simulation failed" && exit 1
echo "Simulation passed"
